//--- all.f
+incdir+include
hw/bus_pkg.sv
hw/bus_req_if.sv
hw/bus_decode.sv
hw/data_mem.sv
hw/timer.sv
hw/gpio.sv
hw/bus_resp.sv
hw/bus.sv
sim/tb_bus.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_bus
FILELIST  := all.f
OBJ_DIR   := obj_dir
FLAGS     := --binary --timing --assert --timescale 1ns/1ps

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) include/bus_cfg.svh

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

//--- sim/tb_bus.sv
`default_nettype none

`include "bus_cfg.svh"

module tb_bus import bus_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int MEM_OPS      = 200;
    localparam int IRQ_WAIT     = 200;
    localparam int IDX_W        = $clog2(`BUS_MEM_DEPTH);
    localparam int TEST_CYCLES  = RESET_CYCLES + 32 + MEM_OPS + 64 + 80 + IRQ_WAIT + 40;

    logic  clk_i;
    logic  rst_i;
    logic  req;
    logic  we;
    be_t   be;
    addr_t addr;
    word_t wdata;
    logic  rvalid;
    word_t rdata;
    logic  irq_ack;
    logic  irq;
    gpio_t pins_in;
    gpio_t pins_out;

    string       test_name;
    logic [31:0] lfsr_q = 32'h46e7;

    // reference model state advanced on every rising edge
    word_t m_mem [`BUS_MEM_DEPTH];
    bit    m_written [`BUS_MEM_DEPTH];  // word fully written at least once.
    logic  m_en;
    word_t m_count;
    word_t m_cmp;
    logic  m_irq;
    gpio_t m_out;
    gpio_t m_meta;
    gpio_t m_sync;
    logic  exp_rvalid;
    logic  chk_data;
    word_t exp_data;

    bus i_dut (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .data_req_i    (req),
        .data_we_i     (we),
        .data_be_i     (be),
        .data_addr_i   (addr),
        .data_wdata_i  (wdata),
        .data_rvalid_o (rvalid),
        .data_rdata_o  (rdata),
        .irq_ack_i     (irq_ack),
        .irq_o         (irq),
        .gpio_i        (pins_in),
        .gpio_o        (pins_out)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    initial begin
        #(2 * TEST_CYCLES * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("TB FAILED");
        $fatal(1);
    end

    // ======================================================================
    // helpers
    // ======================================================================
    function automatic logic [31:0] take_bits(int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r      = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic word_t merge_lanes(word_t old_w, word_t new_w, be_t lanes);
        word_t r;
        r = old_w;
        for (int i = 0; i < 4; i++) begin
            if (lanes[i]) begin
                r[8*i +: 8] = new_w[8*i +: 8];
            end
        end
        return r;
    endfunction

    // 16-word window with bits 12:10 varied to hit the aliases.
    function automatic addr_t mem_addr(logic [3:0] w);
        logic [31:0] hi;
        hi = take_bits(3);
        return {1'b0, hi[2:0], 6'b101101, w};
    endfunction

    function automatic addr_t periph_addr(logic [2:0] s, reg_off_t off);
        return {1'b1, 4'h0, s, off};
    endfunction

    function automatic word_t predict(addr_t a);
        word_t r;
        r = '0;
        if (!a[13]) begin
            r = m_mem[a[IDX_W-1:0]];
        end else if (a[8:6] == `BUS_SEL_TIMER) begin
            case (a[5:0])
                `TMR_CTRL:  r = {31'd0, m_en};
                `TMR_COUNT: r = m_count;
                `TMR_CMP:   r = m_cmp;
                `TMR_STAT:  r = {31'd0, m_irq};
                default:    r = '0;
            endcase
        end else if (a[8:6] == `BUS_SEL_GPIO) begin
            case (a[5:0])
                `GPIO_IN:  r = {16'h0, m_sync};
                `GPIO_OUT: r = {16'h0, m_out};
                default:   r = '0;
            endcase
        end
        return r;
    endfunction

    task automatic report_mismatch(string what, word_t exp_v, word_t act_v);
        $display("[FAIL] %s: %s expected %h actual %h", test_name, what, exp_v, act_v);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic access(logic w, be_t lanes, addr_t a, word_t d);
        @(negedge clk_i);
        req   = 1'b1;
        we    = w;
        be    = lanes;
        addr  = a;
        wdata = d;
    endtask

    task automatic idle(int n);
        repeat (n) begin
            @(negedge clk_i);
            req = 1'b0;
            we  = 1'b0;
        end
    endtask

    // ======================================================================
    // reference model
    // ======================================================================
    always @(posedge clk_i) begin : ref_model
        logic  wr_mem;
        logic  wr_tmr;
        logic  wr_gpio;
        logic  match;
        logic  clr;
        word_t tmp;
        wr_mem  = req && we && !addr[13];
        wr_tmr  = req && we && addr[13] && (addr[8:6] == `BUS_SEL_TIMER);
        wr_gpio = req && we && addr[13] && (addr[8:6] == `BUS_SEL_GPIO);
        exp_rvalid <= !rst_i && req;
        exp_data   <= predict(addr);                    // state before the edge.
        chk_data   <= !rst_i && req && !we && (addr[13] || m_written[addr[IDX_W-1:0]]);
        m_sync = m_meta;
        m_meta = pins_in;
        if (rst_i) begin
            m_en    = 1'b0;
            m_count = '0;
            m_cmp   = '0;
            m_irq   = 1'b0;
            m_out   = '0;
        end else begin
            match = m_en && (m_count == m_cmp);
            clr   = wr_tmr && (addr[5:0] == `TMR_STAT) && be[0] && wdata[0];
            if (match) begin
                m_irq = 1'b1;
            end else if (irq_ack || clr) begin
                m_irq = 1'b0;
            end
            if (wr_tmr && addr[5:0] == `TMR_COUNT) begin
                m_count = merge_lanes(m_count, wdata, be);
            end else if (m_en) begin
                m_count = m_count + 32'd1;
            end
            if (wr_tmr && addr[5:0] == `TMR_CMP) begin
                m_cmp = merge_lanes(m_cmp, wdata, be);
            end
            if (wr_tmr && addr[5:0] == `TMR_CTRL && be[0]) begin
                m_en = wdata[0];
            end
            if (wr_gpio && addr[5:0] == `GPIO_OUT) begin
                tmp   = merge_lanes({16'h0, m_out}, wdata, be);
                m_out = tmp[15:0];                      // upper lanes dropped.
            end
            if (wr_mem) begin
                m_mem[addr[IDX_W-1:0]] = merge_lanes(m_mem[addr[IDX_W-1:0]], wdata, be);
                if (be == 4'hf) begin
                    m_written[addr[IDX_W-1:0]] = 1'b1;
                end
            end
        end
    end

    a_rvalid: assert property (@(posedge clk_i) disable iff (rst_i) rvalid == exp_rvalid)
        else report_mismatch("rvalid", 32'($sampled(exp_rvalid)), 32'($sampled(rvalid)));
    a_rdata: assert property (@(posedge clk_i) disable iff (rst_i) chk_data |-> rdata == exp_data)
        else report_mismatch("rdata", $sampled(exp_data), $sampled(rdata));
    a_gpio_o: assert property (@(posedge clk_i) disable iff (rst_i) pins_out == m_out)
        else report_mismatch("gpio_o", 32'($sampled(m_out)), 32'($sampled(pins_out)));
    a_irq: assert property (@(posedge clk_i) disable iff (rst_i) irq == m_irq)
        else report_mismatch("irq_o", 32'($sampled(m_irq)), 32'($sampled(irq)));

    // ======================================================================
    // tests
    // ======================================================================
    initial begin
        addr_t a;
        be_t   lanes;
        rst_i     = 1'b1;
        req       = 1'b1;                               // ignored while in reset.
        we        = 1'b0;
        be        = '0;
        addr      = '0;
        wdata     = '0;
        irq_ack   = 1'b0;
        pins_in   = '0;
        test_name = "reset";
        repeat (RESET_CYCLES) @(negedge clk_i);
        rst_i = 1'b0;
        req   = 1'b0;
        idle(4);                                        // rvalid must stay low.

        test_name = "memory";
        for (int i = 0; i < 16; i++) begin
            access(1'b1, 4'hf, mem_addr(4'(i)), take_bits(32));
        end
        for (int i = 0; i < MEM_OPS; i++) begin
            a = mem_addr(4'(take_bits(4)));
            if (take_bits(1) == 32'd1) begin
                lanes = be_t'(take_bits(4));
                access(1'b1, (lanes == 4'h0) ? 4'hf : lanes, a, take_bits(32));
            end else begin
                access(1'b0, 4'h0, a, '0);
            end
        end
        for (int i = 0; i < 16; i++) begin
            access(1'b0, 4'h0, mem_addr(4'(i)), '0);
        end

        test_name = "gpio";
        for (int i = 0; i < 8; i++) begin
            lanes = be_t'(take_bits(4));
            access(1'b1, (lanes == 4'h0) ? 4'h3 : lanes, periph_addr(`BUS_SEL_GPIO, `GPIO_OUT),
                   take_bits(32));
            access(1'b0, 4'h0, periph_addr(`BUS_SEL_GPIO, `GPIO_OUT), '0);
        end
        for (int i = 0; i < 4; i++) begin
            @(negedge clk_i);
            req     = 1'b0;
            we      = 1'b0;
            pins_in = gpio_t'(take_bits(16));
            idle(1);
            access(1'b0, 4'h0, periph_addr(`BUS_SEL_GPIO, `GPIO_IN), '0);   // third edge.
        end

        test_name = "reserved";
        foreach (lanes[i]) begin
            for (int s = 0; s < 8; s++) begin
                if (s != 3 && s != 5 && s[1:0] == i[1:0]) begin
                    a = periph_addr(3'(s), reg_off_t'(take_bits(6)));
                    access(1'b1, 4'hf, a, take_bits(32));
                    access(1'b0, 4'h0, a, '0);
                end
            end
        end
        access(1'b0, 4'h0, periph_addr(`BUS_SEL_GPIO, `GPIO_OUT), '0);
        for (int i = 0; i < 16; i++) begin
            access(1'b0, 4'h0, mem_addr(4'(i)), '0);
        end

        test_name = "timer";
        access(1'b1, 4'hf, periph_addr(`BUS_SEL_TIMER, `TMR_CMP), 32'd60);
        access(1'b1, 4'hf, periph_addr(`BUS_SEL_TIMER, `TMR_COUNT), 32'd0);
        access(1'b1, 4'h1, periph_addr(`BUS_SEL_TIMER, `TMR_CTRL), 32'd1);
        for (int i = 0; i < IRQ_WAIT && !irq; i++) begin
            idle(1);
        end
        if (!irq) begin
            $display("timer interrupt never rose after compare and enable were written");
            $display("TB FAILED");
            $fatal(1);
        end
        access(1'b0, 4'h0, periph_addr(`BUS_SEL_TIMER, `TMR_STAT), '0);
        access(1'b0, 4'h0, periph_addr(`BUS_SEL_TIMER, `TMR_CTRL), '0);
        @(negedge clk_i);
        req     = 1'b0;
        irq_ack = 1'b1;
        @(negedge clk_i);
        irq_ack = 1'b0;
        access(1'b0, 4'h0, periph_addr(`BUS_SEL_TIMER, `TMR_STAT), '0);
        access(1'b1, 4'h1, periph_addr(`BUS_SEL_TIMER, `TMR_CTRL), 32'd0);
        access(1'b1, 4'hf, periph_addr(`BUS_SEL_TIMER, `TMR_COUNT), take_bits(32));
        idle(10);
        access(1'b0, 4'h0, periph_addr(`BUS_SEL_TIMER, `TMR_COUNT), '0);
        access(1'b0, 4'h0, periph_addr(`BUS_SEL_TIMER, `TMR_COUNT), '0);
        idle(4);

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/bus.sv
`default_nettype none

module bus import bus_pkg::*; (
    input  wire logic  clk_i,
    input  wire logic  rst_i,
    // core data port
    input  wire logic  data_req_i,
    input  wire logic  data_we_i,
    input  wire be_t   data_be_i,
    input  wire addr_t data_addr_i,
    input  wire word_t data_wdata_i,
    output logic       data_rvalid_o,
    output word_t      data_rdata_o,
    // timer interrupt
    input  wire logic  irq_ack_i,
    output logic       irq_o,
    // pins
    input  wire gpio_t gpio_i,
    output gpio_t      gpio_o
);

    bus_req_if i_req ();

    word_t mem_rdata;
    word_t tmr_rdata;
    word_t gpio_rdata;

    // ======================================================================
    // decode stage
    // ======================================================================
    bus_decode i_decode (
        .req_i   (data_req_i),
        .we_i    (data_we_i),
        .be_i    (data_be_i),
        .addr_i  (data_addr_i),
        .wdata_i (data_wdata_i),
        .req_o   (i_req.decode)
    );

    // ======================================================================
    // targets
    // ======================================================================
    data_mem i_data_mem (
        .clk_i   (clk_i),
        .req_i   (i_req.target),
        .rdata_o (mem_rdata)
    );

    timer i_timer (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .req_i     (i_req.target),
        .irq_ack_i (irq_ack_i),
        .rdata_o   (tmr_rdata),
        .irq_o     (irq_o)
    );

    gpio i_gpio (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .req_i   (i_req.target),
        .gpio_i  (gpio_i),
        .gpio_o  (gpio_o),
        .rdata_o (gpio_rdata)
    );

    // ======================================================================
    // response stage
    // ======================================================================
    bus_resp i_resp (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .req_i        (data_req_i),
        .sel_i        (i_req.sel),
        .mem_rdata_i  (mem_rdata),
        .tmr_rdata_i  (tmr_rdata),
        .gpio_rdata_i (gpio_rdata),
        .rvalid_o     (data_rvalid_o),
        .rdata_o      (data_rdata_o)
    );

endmodule

`default_nettype wire

//--- hw/bus_resp.sv
`default_nettype none

`include "bus_cfg.svh"

module bus_resp import bus_pkg::*; (
    input  wire logic  clk_i,
    input  wire logic  rst_i,
    input  wire logic  req_i,
    input  wire sel_t  sel_i,
    input  wire word_t mem_rdata_i,
    input  wire word_t tmr_rdata_i,
    input  wire word_t gpio_rdata_i,
    output logic       rvalid_o,
    output word_t      rdata_o
);

    word_t rdata_nxt;

    // unselected targets drop out, so holes read as zero
    assign rdata_nxt = ({32{sel_i[`BUS_SEL_BIT_MEM]}}  & mem_rdata_i)
                     | ({32{sel_i[`BUS_SEL_BIT_TMR]}}  & tmr_rdata_i)
                     | ({32{sel_i[`BUS_SEL_BIT_GPIO]}} & gpio_rdata_i);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rvalid_o <= 1'b0;
        end else begin
            rvalid_o <= req_i;                  // one pulse per request.
        end
    end

    always_ff @(posedge clk_i) begin
        rdata_o <= rdata_nxt;
    end

    assert property (@(posedge clk_i) disable iff (rst_i)
        rvalid_o && $past(rvalid_o) |-> $past(req_i) && $past(req_i, 2))
        else $error("bus_resp: rvalid held without back-to-back requests");

endmodule

`default_nettype wire

//--- hw/gpio.sv
`default_nettype none

`include "bus_cfg.svh"

module gpio import bus_pkg::*; (
    input  wire logic  clk_i,
    input  wire logic  rst_i,
    bus_req_if.target  req_i,
    input  wire gpio_t gpio_i,
    output gpio_t      gpio_o,
    output word_t      rdata_o
);

    gpio_t in_meta;
    gpio_t in_sync;
    logic  wr;
    word_t out_merged;

    assign wr         = req_i.we & req_i.sel[`BUS_SEL_BIT_GPIO];
    assign out_merged = be_merge({16'h0, gpio_o}, req_i.wdata, req_i.be);

    // two flops against metastability on the pins
    always_ff @(posedge clk_i) begin
        in_meta <= gpio_i;
        in_sync <= in_meta;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            gpio_o <= '0;
        end else if (wr && req_i.off == `GPIO_OUT) begin
            gpio_o <= out_merged[15:0];                     // lanes 0 and 1 only.
        end
    end

    always_comb begin
        case (req_i.off)
            `GPIO_IN:  rdata_o = {16'h0, in_sync};
            `GPIO_OUT: rdata_o = {16'h0, gpio_o};
            default:   rdata_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/timer.sv
`default_nettype none

`include "bus_cfg.svh"

module timer import bus_pkg::*; (
    input  wire logic  clk_i,
    input  wire logic  rst_i,
    bus_req_if.target  req_i,
    input  wire logic  irq_ack_i,
    output word_t      rdata_o,
    output logic       irq_o
);

    logic  en;
    word_t count;
    word_t cmp;
    logic  wr;
    logic  match;
    logic  stat_clr;

    assign wr       = req_i.we & req_i.sel[`BUS_SEL_BIT_TMR];
    assign match    = en & (count == cmp);
    assign stat_clr = wr & (req_i.off == `TMR_STAT) & req_i.be[0] & req_i.wdata[0];

    // ======================================================================
    // registers
    // ======================================================================
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            en    <= 1'b0;
            count <= '0;
            cmp   <= '0;
            irq_o <= 1'b0;
        end else begin
            if (wr && req_i.off == `TMR_CTRL && req_i.be[0]) begin
                en <= req_i.wdata[0];
            end
            if (wr && req_i.off == `TMR_COUNT) begin
                count <= be_merge(count, req_i.wdata, req_i.be);   // write wins.
            end else if (en) begin
                count <= count + 32'd1;
            end
            if (wr && req_i.off == `TMR_CMP) begin
                cmp <= be_merge(cmp, req_i.wdata, req_i.be);
            end
            // a new match beats a clear in the same cycle
            if (match) begin
                irq_o <= 1'b1;
            end else if (irq_ack_i || stat_clr) begin
                irq_o <= 1'b0;
            end
        end
    end

    always_comb begin
        case (req_i.off)
            `TMR_CTRL:  rdata_o = {31'd0, en};
            `TMR_COUNT: rdata_o = count;
            `TMR_CMP:   rdata_o = cmp;
            `TMR_STAT:  rdata_o = {31'd0, irq_o};
            default:    rdata_o = '0;
        endcase
    end

    // the interrupt may only be raised by a match seen while enabled
    assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(irq_o) |-> $past(en))
        else $error("timer: irq raised while disabled");

endmodule

`default_nettype wire

//--- hw/data_mem.sv
`default_nettype none

`include "bus_cfg.svh"

module data_mem import bus_pkg::*; (
    input  wire logic  clk_i,
    bus_req_if.target  req_i,
    output word_t      rdata_o
);

    word_t mem [`BUS_MEM_DEPTH];

    logic wr;

    assign wr = req_i.we & req_i.sel[`BUS_SEL_BIT_MEM];

    // ======================================================================
    // byte-lane write, asynchronous read
    // ======================================================================
    always_ff @(posedge clk_i) begin
        if (wr) begin
            for (int i = 0; i < 4; i++) begin
                if (req_i.be[i]) begin
                    mem[req_i.mem_idx][8*i +: 8] <= req_i.wdata[8*i +: 8];
                end
            end
        end
    end

    assign rdata_o = mem[req_i.mem_idx];    // registered later in bus_resp.

endmodule

`default_nettype wire

//--- hw/bus_decode.sv
`default_nettype none

`include "bus_cfg.svh"

module bus_decode import bus_pkg::*; (
    input  wire logic  req_i,
    input  wire logic  we_i,
    input  wire be_t   be_i,
    input  wire addr_t addr_i,
    input  wire word_t wdata_i,
    bus_req_if.decode  req_o
);

    sel_t sel;

    // ======================================================================
    // address decode
    // ======================================================================
    always_comb begin
        sel = '0;
        if (!addr_i[13]) begin
            sel[`BUS_SEL_BIT_MEM] = 1'b1;
        end else begin
            case (addr_i[8:6])          // uart, i2c, qspi, usb fall through.
                `BUS_SEL_TIMER: sel[`BUS_SEL_BIT_TMR]  = 1'b1;
                `BUS_SEL_GPIO:  sel[`BUS_SEL_BIT_GPIO] = 1'b1;
                default:        sel = '0;
            endcase
        end
    end

    assign req_o.sel     = sel;
    assign req_o.we      = req_i & we_i;                    // only with a strobe.
    assign req_o.be      = be_i;
    assign req_o.off     = addr_i[5:0];
    assign req_o.mem_idx = addr_i[$bits(mem_idx_t)-1:0];
    assign req_o.wdata   = wdata_i;

    // a core write with no lanes set is a protocol error upstream
    always_comb begin
        assert final (!(req_i && we_i) || (be_i != '0))
            else $error("bus_decode: write without byte enables");
    end

endmodule

`default_nettype wire

//--- hw/bus_req_if.sv
`default_nettype none

interface bus_req_if import bus_pkg::*; ();

    sel_t     sel;                      // one-hot target select.
    logic     we;                       // write, qualified by the request.
    be_t      be;
    reg_off_t off;                      // peripheral register offset.
    mem_idx_t mem_idx;                  // data memory word index.
    word_t    wdata;

    modport decode (
        output sel, we, be, off, mem_idx, wdata
    );

    modport target (
        input sel, we, be, off, mem_idx, wdata
    );

endinterface

`default_nettype wire

//--- hw/bus_pkg.sv
`default_nettype none

`include "bus_cfg.svh"

package bus_pkg;

    typedef logic [31:0] word_t;        // one bus data word.
    typedef logic [3:0]  be_t;          // byte enables.
    typedef logic [13:0] addr_t;        // word address.
    typedef logic [5:0]  reg_off_t;     // peripheral register offset.
    typedef logic [$clog2(`BUS_MEM_DEPTH)-1:0] mem_idx_t;
    typedef logic [15:0] gpio_t;        // gpio pins.
    typedef logic [2:0]  sel_t;         // one-hot target select.

    // merges the enabled byte lanes of a write into the old word
    function automatic word_t be_merge(word_t old_w, word_t new_w, be_t be);
        word_t res;
        res = old_w;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                res[8*i +: 8] = new_w[8*i +: 8];
            end
        end
        return res;
    endfunction

endpackage

`default_nettype wire

//--- include/bus_cfg.svh
`ifndef BUS_CFG_SVH
`define BUS_CFG_SVH

// ==========================================================================
// data memory
// ==========================================================================
`define BUS_MEM_DEPTH     1024          // words of data memory.

// ==========================================================================
// peripheral map, addr[13] set, select in addr[8:6], offset in addr[5:0]
// ==========================================================================
`define BUS_SEL_TIMER     3'd3
`define BUS_SEL_GPIO      3'd5

// bit positions inside the one-hot target select
`define BUS_SEL_BIT_MEM   0
`define BUS_SEL_BIT_TMR   1
`define BUS_SEL_BIT_GPIO  2

`define TMR_CTRL          6'd0          // bit 0 enables counting.
`define TMR_COUNT         6'd1
`define TMR_CMP           6'd2
`define TMR_STAT          6'd3          // bit 0 is the pending irq.

`define GPIO_IN           6'd0
`define GPIO_OUT          6'd1

`endif
